/* common/mult16_pkg.sv */
`default_nettype none

package mult16_pkg;

    localparam int OP_W    = 16;
    localparam int PROD_W  = 2 * OP_W;
    localparam int AXIL_AW = 4;
    localparam int AXIL_DW = 32;

    // register map, byte offsets
    localparam logic [AXIL_AW-1:0] ADDR_OPERANDS = 4'h0;
    localparam logic [AXIL_AW-1:0] ADDR_STATUS   = 4'h4;
    localparam logic [AXIL_AW-1:0] ADDR_PRODUCT  = 4'h8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // request to response, in clock cycles
    localparam int CORE_LATENCY = 3;

    // each 3:2 layer turns every full group of three rows into two
    function automatic int csa_layers(input int rows);
        int n;
        int layers;
        n = rows;
        layers = 0;
        while (n > 2) begin
            n = 2 * (n / 3) + n % 3;
            layers++;
        end
        return layers;
    endfunction

    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_AW-1:0]     awaddr;
        logic                   wvalid;
        logic [AXIL_DW-1:0]     wdata;
        logic [AXIL_DW/8-1:0]   wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_AW-1:0]     araddr;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DW-1:0]     rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic                   valid;
        logic [OP_W-1:0]        a;
        logic [OP_W-1:0]        b;
    } mult_req_t;

    typedef struct packed {
        logic                   valid;
        logic [PROD_W-1:0]      product;
    } mult_rsp_t;

    // row i already sits at weight i
    typedef logic [OP_W-1:0][PROD_W-1:0] pp_rows_t;

endpackage

`default_nettype wire

/* hw/axil_mult_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mult_regs
    import mult16_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire axil_req_t axil_req,
    output axil_rsp_t      axil_rsp,
    output mult_req_t      mult_req,
    input  wire mult_rsp_t mult_rsp
);

    logic               bvalid_q;
    logic [1:0]         bresp_q;
    logic               rvalid_q;
    logic [1:0]         rresp_q;
    logic [AXIL_DW-1:0] rdata_q;
    logic [AXIL_DW-1:0] operands_q;
    logic               done_q;
    logic [PROD_W-1:0]  product_q;
    logic               req_valid_q;

    logic               wr_ready;
    logic               rd_ready;
    logic               wr_fire;
    logic               rd_fire;
    logic               op_write;
    logic [AXIL_DW-1:0] rd_data;
    logic [1:0]         rd_resp;

    // one outstanding response per channel
    assign wr_ready = !bvalid_q;
    assign rd_ready = !rvalid_q;

    assign wr_fire  = axil_req.awvalid && axil_req.wvalid && wr_ready;
    assign rd_fire  = axil_req.arvalid && rd_ready;
    assign op_write = wr_fire && (axil_req.awaddr == ADDR_OPERANDS);

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            ADDR_OPERANDS: rd_data = operands_q;
            ADDR_STATUS:   rd_data = AXIL_DW'(done_q);
            ADDR_PRODUCT:  rd_data = AXIL_DW'(product_q);
            default:       rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // only the operand register takes writes
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_q <= op_write ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (op_write) begin
            operands_q <= axil_req.wdata;
        end
        if (mult_rsp.valid) begin
            product_q <= mult_rsp.product;
        end
    end

    // a fresh operand write wins over a response landing the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (op_write) begin
            done_q <= 1'b0;
        end else if (mult_rsp.valid) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= op_write;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = rd_ready;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    // operands_q was loaded on the handshake edge, so it lines up with valid
    always_comb begin
        mult_req.valid = req_valid_q;
        mult_req.a     = operands_q[OP_W-1:0];
        mult_req.b     = operands_q[2*OP_W-1:OP_W];
    end

    a_b_hold: assert property (
        @(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp)
    ) else $error("write response dropped or changed while bready was low");

    a_r_hold: assert property (
        @(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=>
            axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp)
    ) else $error("read response dropped or changed while rready was low");

endmodule

`default_nettype wire

/* hw/mult16_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mult16_top
    import mult16_pkg::*;
#(
    parameter int OP_W      = mult16_pkg::OP_W,
    parameter int CLA_GROUP = 4
) (
    input  wire            clk,
    input  wire            rst,
    input  wire axil_req_t axil_req,
    output axil_rsp_t      axil_rsp
);

    mult_req_t mult_req;
    mult_rsp_t mult_rsp;

    axil_mult_regs axil_mult_regs_i (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .mult_req (mult_req),
        .mult_rsp (mult_rsp)
    );

    // three-stage pipelined multiplier
    mult_core #(
        .OP_W      (OP_W),
        .CLA_GROUP (CLA_GROUP)
    ) mult_core_i (
        .clk      (clk),
        .rst      (rst),
        .mult_req (mult_req),
        .mult_rsp (mult_rsp)
    );

endmodule

`default_nettype wire

/* mult16.f */
+incdir+tests
common/mult16_pkg.sv
mult_core/pp_gen.sv
mult_core/csa_tree.sv
mult_core/cla_adder.sv
mult_core/mult_core.sv
hw/axil_mult_regs.sv
hw/mult16_top.sv
tests/tb_mult16_top.sv

/* mult_core/cla_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module cla_adder
    import mult16_pkg::*;
#(
    parameter int OP_W      = mult16_pkg::OP_W,
    parameter int CLA_GROUP = 4
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [PROD_W-1:0] sum_row,
    input  wire [PROD_W-1:0] carry_row,
    input  wire              csa_valid,
    output mult_rsp_t        mult_rsp
);

    localparam int ADD_W = 2 * OP_W;
    localparam int NG    = ADD_W / CLA_GROUP;

    logic [ADD_W-1:0]  bit_g;
    logic [ADD_W-1:0]  bit_p;
    logic [ADD_W-1:0]  sum_d;
    logic [NG-1:0]     grp_g;
    logic [NG-1:0]     grp_p;
    logic [NG-1:0]     grp_c;
    logic [PROD_W-1:0] prod_q;
    logic              valid_q;

    assign bit_g = sum_row & carry_row;
    assign bit_p = sum_row ^ carry_row;

    always_comb begin
        logic g_acc;
        logic p_acc;
        for (int j = 0; j < NG; j++) begin
            g_acc = 1'b0;
            p_acc = 1'b1;
            for (int b = 0; b < CLA_GROUP; b++) begin
                g_acc = bit_g[j*CLA_GROUP+b] | (bit_p[j*CLA_GROUP+b] & g_acc);
                p_acc = p_acc & bit_p[j*CLA_GROUP+b];
            end
            grp_g[j] = g_acc;
            grp_p[j] = p_acc;
        end
    end

    // carry into group j, flattened over all lower groups, no carry in
    always_comb begin
        logic term;
        logic c_acc;
        grp_c = '0;
        for (int j = 1; j < NG; j++) begin
            c_acc = 1'b0;
            for (int k = 0; k < j; k++) begin
                term = grp_g[k];
                for (int m = k + 1; m < j; m++) begin
                    term = term & grp_p[m];
                end
                c_acc = c_acc | term;
            end
            grp_c[j] = c_acc;
        end
    end

    // ripple inside each group from its lookahead carry
    always_comb begin
        logic cy;
        for (int j = 0; j < NG; j++) begin
            cy = grp_c[j];
            for (int b = 0; b < CLA_GROUP; b++) begin
                sum_d[j*CLA_GROUP+b] = bit_p[j*CLA_GROUP+b] ^ cy;
                cy = bit_g[j*CLA_GROUP+b] | (bit_p[j*CLA_GROUP+b] & cy);
            end
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= sum_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= csa_valid;
        end
    end

    always_comb begin
        mult_rsp.valid   = valid_q;
        mult_rsp.product = prod_q;
    end

endmodule

`default_nettype wire

/* mult_core/csa_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_tree
    import mult16_pkg::*;
#(
    parameter int OP_W = mult16_pkg::OP_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire pp_rows_t     pp_rows,
    input  wire               pp_valid,
    output logic [PROD_W-1:0] sum_row,
    output logic [PROD_W-1:0] carry_row,
    output logic              csa_valid
);

    localparam int LAYERS = csa_layers(OP_W);

    // rows still alive on entry to a layer
    function automatic int rows_at(input int layer);
        int n;
        n = OP_W;
        for (int k = 0; k < layer; k++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    logic [PROD_W-1:0] stage [LAYERS+1][OP_W];
    logic [PROD_W-1:0] row_total;

    for (genvar r = 0; r < OP_W; r++) begin : g_in
        assign stage[0][r] = pp_rows[r];
    end

    for (genvar l = 0; l < LAYERS; l++) begin : g_layer
        localparam int N_IN   = rows_at(l);
        localparam int N_OUT  = rows_at(l + 1);
        localparam int GROUPS = N_IN / 3;

        for (genvar g = 0; g < GROUPS; g++) begin : g_csa
            logic [PROD_W-1:0] x;
            logic [PROD_W-1:0] y;
            logic [PROD_W-1:0] z;

            assign x = stage[l][3*g];
            assign y = stage[l][3*g+1];
            assign z = stage[l][3*g+2];

            // one full adder per column with its carry one weight up
            assign stage[l+1][2*g]   = x ^ y ^ z;
            assign stage[l+1][2*g+1] = ((x & y) | (y & z) | (x & z)) << 1;
        end

        // leftovers skip this layer
        for (genvar r = 0; r < N_IN % 3; r++) begin : g_pass
            assign stage[l+1][2*GROUPS+r] = stage[l][3*GROUPS+r];
        end

        for (genvar r = N_OUT; r < OP_W; r++) begin : g_idle
            assign stage[l+1][r] = '0;
        end
    end

    always_ff @(posedge clk) begin
        sum_row   <= stage[LAYERS][0];
        carry_row <= stage[LAYERS][1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csa_valid <= 1'b0;
        end else begin
            csa_valid <= pp_valid;
        end
    end

    // plain sum of all input rows
    always_comb begin
        row_total = '0;
        for (int r = 0; r < OP_W; r++) begin
            row_total = row_total + pp_rows[r];
        end
    end

    // the two output rows must still add up to the input row total
    a_valid_step: assert property (
        @(posedge clk) disable iff (rst)
        pp_valid |=> csa_valid && (sum_row + carry_row == $past(row_total))
    ) else $error("csa rows lost pp_valid or no longer add up to the partial products");

endmodule

`default_nettype wire

/* mult_core/mult_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_core
    import mult16_pkg::*;
#(
    parameter int OP_W      = mult16_pkg::OP_W,
    parameter int CLA_GROUP = 4
) (
    input  wire            clk,
    input  wire            rst,
    input  wire mult_req_t mult_req,
    output mult_rsp_t      mult_rsp
);

    pp_rows_t          pp_rows;
    logic              pp_valid;
    logic [PROD_W-1:0] sum_row;
    logic [PROD_W-1:0] carry_row;
    logic              csa_valid;

    pp_gen #(.OP_W(OP_W)) pp_gen_i (
        .clk      (clk),
        .rst      (rst),
        .mult_req (mult_req),
        .pp_rows  (pp_rows),
        .pp_valid (pp_valid)
    );

    csa_tree #(.OP_W(OP_W)) csa_tree_i (
        .clk       (clk),
        .rst       (rst),
        .pp_rows   (pp_rows),
        .pp_valid  (pp_valid),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .csa_valid (csa_valid)
    );

    cla_adder #(.OP_W(OP_W), .CLA_GROUP(CLA_GROUP)) cla_adder_i (
        .clk       (clk),
        .rst       (rst),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .csa_valid (csa_valid),
        .mult_rsp  (mult_rsp)
    );

    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        mult_rsp.valid == $past(mult_req.valid, CORE_LATENCY)
    ) else $error("core response valid does not match request valid %0d cycles back",
                  CORE_LATENCY);

endmodule

`default_nettype wire

/* mult_core/pp_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pp_gen
    import mult16_pkg::*;
#(
    parameter int OP_W = mult16_pkg::OP_W
) (
    input  wire            clk,
    input  wire            rst,
    input  wire mult_req_t mult_req,
    output pp_rows_t       pp_rows,
    output logic           pp_valid
);

    pp_rows_t rows_d;

    // row i is a gated by b[i], moved up to weight i
    always_comb begin
        for (int i = 0; i < OP_W; i++) begin
            rows_d[i] = PROD_W'(mult_req.a & {OP_W{mult_req.b[i]}}) << i;
        end
    end

    always_ff @(posedge clk) begin
        pp_rows <= rows_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= mult_req.valid;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mult16_top \
    -f mult16.f \
    -o sim_mult16

./obj_dir/sim_mult16 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* tests/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// clock edges allowed for one handshake, and status reads allowed per poll
localparam int WAIT_LIMIT = 40;
localparam int POLL_LIMIT = 10;

task automatic log_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("timeout at %0t: no %s seen, remaining bus accesses skipped", $time, what);
endtask

// stall > 0 holds bready low for that many cycles once bvalid is up
task automatic write_reg(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data,
                         input logic [1:0] resp, input int stall);
    int   n;
    logic ok;
    if (timed_out) begin
        return;
    end
    exp_bresp        = resp;
    wr_check         = 1'b1;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.bready  = (stall == 0);
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!(axil_rsp.awready && axil_rsp.wready) && n < WAIT_LIMIT);
    ok = axil_rsp.awready && axil_rsp.wready;
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    if (!ok) begin
        wr_check = 1'b0;
        log_timeout("write address and data handshake");
        return;
    end
    if (stall > 0) begin
        repeat (stall) @(posedge clk);
        #1;
        axil_req.bready = 1'b1;
    end
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!axil_rsp.bvalid && n < WAIT_LIMIT);
    ok = axil_rsp.bvalid;
    #1;
    axil_req.bready = 1'b0;
    wr_check        = 1'b0;
    if (!ok) begin
        log_timeout("write response");
    end
endtask

task automatic read_reg(input logic [AXIL_AW-1:0] addr, input logic check,
                        input logic [AXIL_DW-1:0] exp_data, input logic [1:0] exp_resp,
                        input int stall, output logic [AXIL_DW-1:0] data);
    int   n;
    logic ok;
    data = '0;
    if (timed_out) begin
        return;
    end
    rd_check         = check;
    exp_rdata        = exp_data;
    exp_rresp        = exp_resp;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = (stall == 0);
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!axil_rsp.arready && n < WAIT_LIMIT);
    ok = axil_rsp.arready;
    #1;
    axil_req.arvalid = 1'b0;
    if (!ok) begin
        rd_check = 1'b0;
        log_timeout("read address handshake");
        return;
    end
    if (stall > 0) begin
        repeat (stall) @(posedge clk);
        #1;
        axil_req.rready = 1'b1;
    end
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!axil_rsp.rvalid && n < WAIT_LIMIT);
    ok   = axil_rsp.rvalid;
    data = axil_rsp.rdata;
    #1;
    axil_req.rready = 1'b0;
    rd_check        = 1'b0;
    if (!ok) begin
        log_timeout("read response");
    end
endtask

task automatic poll_done();
    logic [AXIL_DW-1:0] status;
    int                 n;
    status = '0;
    n = 0;
    while (!status[0] && n < POLL_LIMIT && !timed_out) begin
        read_reg(ADDR_STATUS, 1'b0, '0, RESP_OKAY, 0, status);
        n++;
    end
    if (!status[0] && !timed_out) begin
        log_timeout("done bit in the status register");
    end
endtask

`endif

/* tests/tb_mult16_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mult16_top
    import mult16_pkg::*;
();

    logic               clk;
    logic               rst;
    axil_req_t          axil_req;
    axil_rsp_t          axil_rsp;

    int                 errors;
    int                 timeouts;
    logic               timed_out;
    logic               rd_check;
    logic               wr_check;
    logic [AXIL_DW-1:0] exp_rdata;
    logic [1:0]         exp_rresp;
    logic [1:0]         exp_bresp;
    logic [PROD_W-1:0]  last_product;
    logic [AXIL_DW-1:0] rd_word;

    logic               done;
    logic               op_fire;
    logic [5:0]         idle_flags;
    logic [2:0]         b_now;
    logic [AXIL_DW+2:0] r_now;
    logic [2:0]         prev_b;
    logic [AXIL_DW+2:0] prev_r;
    logic               b_stalled;
    logic               r_stalled;

    mult16_top mult16_top_i (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    `include "tb_axil_tasks.svh"

    assign done    = mult16_top_i.axil_mult_regs_i.done_q;
    assign op_fire = axil_req.awvalid && axil_req.wvalid && axil_rsp.awready
                     && axil_rsp.wready && (axil_req.awaddr == ADDR_OPERANDS);
    assign idle_flags = {axil_rsp.awready, axil_rsp.wready, axil_rsp.arready,
                         axil_rsp.bvalid, axil_rsp.rvalid, done};
    assign b_now = {axil_rsp.bvalid, axil_rsp.bresp};
    assign r_now = {axil_rsp.rvalid, axil_rsp.rresp, axil_rsp.rdata};

    // last cycle's response, to compare against while ready is low
    always @(posedge clk) begin
        prev_b    <= b_now;
        prev_r    <= r_now;
        b_stalled <= axil_rsp.bvalid && !axil_req.bready;
        r_stalled <= axil_rsp.rvalid && !axil_req.rready;
    end

    a_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> idle_flags == 6'b111000)
        else begin
            errors++;
            $display("FAILED %0t: {awready,wready,arready,bvalid,rvalid,done} expected %b, got %b",
                     $time, 6'b111000, $sampled(idle_flags));
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        rd_check && axil_rsp.rvalid && axil_req.rready |-> axil_rsp.rdata == exp_rdata)
        else begin
            errors++;
            $display("FAILED %0t: rdata expected %h, got %h",
                     $time, exp_rdata, $sampled(axil_rsp.rdata));
        end

    a_rresp: assert property (@(posedge clk) disable iff (rst)
        rd_check && axil_rsp.rvalid && axil_req.rready |-> axil_rsp.rresp == exp_rresp)
        else begin
            errors++;
            $display("FAILED %0t: rresp expected %b, got %b",
                     $time, exp_rresp, $sampled(axil_rsp.rresp));
        end

    a_bresp: assert property (@(posedge clk) disable iff (rst)
        wr_check && axil_rsp.bvalid && axil_req.bready |-> axil_rsp.bresp == exp_bresp)
        else begin
            errors++;
            $display("FAILED %0t: bresp expected %b, got %b",
                     $time, exp_bresp, $sampled(axil_rsp.bresp));
        end

    a_b_stable: assert property (@(posedge clk) disable iff (rst) b_stalled |-> b_now == prev_b)
        else begin
            errors++;
            $display("FAILED %0t: {bvalid,bresp} expected %b, got %b",
                     $time, $sampled(prev_b), $sampled(b_now));
        end

    a_r_stable: assert property (@(posedge clk) disable iff (rst) r_stalled |-> r_now == prev_r)
        else begin
            errors++;
            $display("FAILED %0t: {rvalid,rresp,rdata} expected %h, got %h",
                     $time, $sampled(prev_r), $sampled(r_now));
        end

    // done drops right after the write and is back four edges later
    a_done_clears: assert property (@(posedge clk) disable iff (rst) $past(op_fire) |-> !done)
        else begin
            errors++;
            $display("FAILED %0t: done expected 0, got %b", $time, $sampled(done));
        end

    a_done_sets: assert property (@(posedge clk) disable iff (rst) $past(op_fire, 5) |-> done)
        else begin
            errors++;
            $display("FAILED %0t: done expected 1, got %b", $time, $sampled(done));
        end

    task automatic multiply_and_check(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b,
                                      input int stall);
        logic [AXIL_DW-1:0] word;
        logic [PROD_W-1:0]  expected;
        logic [AXIL_DW-1:0] seen;
        word     = {b, a};
        expected = PROD_W'(a) * PROD_W'(b);
        write_reg(ADDR_OPERANDS, word, RESP_OKAY, stall);
        // a stalled write response lets done come back before this read
        read_reg(ADDR_STATUS, stall == 0, '0, RESP_OKAY, 0, seen);
        read_reg(ADDR_OPERANDS, 1'b1, word, RESP_OKAY, 0, seen);
        poll_done();
        read_reg(ADDR_PRODUCT, 1'b1, expected, RESP_OKAY, stall, seen);
        last_product = expected;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        void'($urandom(34));
        rst          = 1'b1;
        axil_req     = '0;
        errors       = 0;
        timeouts     = 0;
        timed_out    = 1'b0;
        rd_check     = 1'b0;
        wr_check     = 1'b0;
        exp_rdata    = '0;
        exp_rresp    = RESP_OKAY;
        exp_bresp    = RESP_OKAY;
        last_product = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        read_reg(ADDR_STATUS, 1'b1, '0, RESP_OKAY, 0, rd_word);

        multiply_and_check(16'h0000, 16'h0000, 0);
        multiply_and_check(16'h0001, 16'hffff, 0);
        multiply_and_check(16'hffff, 16'hffff, 0);
        multiply_and_check(16'h8000, 16'h8000, 0);
        multiply_and_check(16'h1234, 16'h5678, 0);
        repeat (200) begin
            multiply_and_check(OP_W'($urandom), OP_W'($urandom), 0);
        end
        repeat (4) begin
            multiply_and_check(OP_W'($urandom), OP_W'($urandom), 2 + $urandom % 8);
        end

        // product register is read-only, and 0xc is unmapped
        write_reg(ADDR_PRODUCT, 32'hdead_beef, RESP_SLVERR, 0);
        read_reg(ADDR_PRODUCT, 1'b1, last_product, RESP_OKAY, 0, rd_word);
        read_reg(4'hc, 1'b1, '0, RESP_SLVERR, 0, rd_word);

        $display("summary: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
